//--- src/emu_pkg.sv
package emu_pkg;

    // Width of one flip-flop scan word and of the RAM scan data.
    localparam int SCAN_W      = 64;

    // Target words in the flip-flop chain.
    localparam int CHAIN_WORDS = 3;

    // Source scan word.
    localparam int SRC_LFSR_LSB = 0;   // LFSR state in the low bits.
    localparam int SRC_CNT_LSB  = 48;  // Sent count.

    // Sink scan word.
    localparam int SNK_SUM      = 0;   // Checksum in the low bits.
    localparam int SNK_CNT_LSB  = 32;  // Received count.
    localparam int SNK_TICK     = 48;  // Pop throttle bit.

    // FIFO scan word holds both pointers and the fill count.
    localparam int FIFO_WR_LSB  = 0;
    localparam int FIFO_RD_LSB  = 4;
    localparam int FIFO_CNT_LSB = 8;

endpackage

//--- src/target_pkg.sv
package target_pkg;

    localparam int DATA_W     = 32;  // Sample width.
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_W      = 4;   // log2 of FIFO_DEPTH.
    localparam int CNT_W      = 16;  // Sent and received counters.

    // Galois LFSR for the sample source.
    localparam logic [DATA_W-1:0] LFSR_SEED = 32'h1;
    localparam logic [DATA_W-1:0] LFSR_TAPS = 32'h80200003;

    // One LFSR step shifts right and folds the taps in when bit 0 falls out.
    function automatic logic [DATA_W-1:0] lfsr_next(input logic [DATA_W-1:0] cur);
        logic [DATA_W-1:0] nxt;
        nxt = cur >> 1;
        if (cur[0])
            nxt = nxt ^ LFSR_TAPS;
        return nxt;
    endfunction

    // Checksum fold. Rotate left by one, then XOR the sample.
    function automatic logic [DATA_W-1:0] fold_sum(
        input logic [DATA_W-1:0] sum,
        input logic [DATA_W-1:0] sample
    );
        return {sum[DATA_W-2:0], sum[DATA_W-1]} ^ sample;
    endfunction

endpackage

//--- src/emu_ctrl.sv
`timescale 1ns/1ps

module emu_ctrl (
    input  logic host_clk,
    input  logic rst_n,
    input  logic run_mode,
    input  logic scan_mode,
    input  logic pause,
    input  logic ff_scan,
    input  logic ram_scan,
    input  logic target_rst,
    output logic step,
    output logic tgt_rst,
    output logic idle
);

    logic run_ok;
    logic rst_pend;

    // The target may only move when the host is not touching its state.
    assign run_ok = run_mode & ~scan_mode & ~pause & ~ff_scan & ~ram_scan;

    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            step <= 1'b0;
        end else begin
            step <= run_ok;
        end
    end

    // Reset request waits for the next step, then is consumed by it.
    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            rst_pend <= 1'b0;
        end else begin
            rst_pend <= target_rst | (rst_pend & ~step);
        end
    end

    assign tgt_rst = step & rst_pend;
    assign idle    = ~step;

endmodule

//--- src/sample_source.sv
`timescale 1ns/1ps

module sample_source import emu_pkg::*, target_pkg::*; (
    input  logic              host_clk,
    input  logic              rst_n,
    input  logic              step,
    input  logic              tgt_rst,
    input  logic              full,
    input  logic              ff_se,
    input  logic [SCAN_W-1:0] ff_di,
    output logic              push,
    output logic [DATA_W-1:0] push_data,
    output logic [SCAN_W-1:0] ff_do
);

    logic [DATA_W-1:0] lfsr;
    logic [CNT_W-1:0]  sent_cnt;

    // The current LFSR value is taken whenever the FIFO has room.
    assign push      = step & ~tgt_rst & ~full;
    assign push_data = lfsr;

    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            lfsr     <= LFSR_SEED;
            sent_cnt <= '0;
        end else if (step) begin
            if (tgt_rst) begin
                lfsr     <= LFSR_SEED;
                sent_cnt <= '0;
            end else if (push) begin
                lfsr     <= lfsr_next(lfsr);
                sent_cnt <= sent_cnt + 1'b1;
            end
        end else if (ff_se) begin
            // Scan shift loads the word from upstream.
            lfsr     <= ff_di[SRC_LFSR_LSB +: DATA_W];
            sent_cnt <= ff_di[SRC_CNT_LSB +: CNT_W];
        end
    end

    always_comb begin
        ff_do = '0;
        ff_do[SRC_LFSR_LSB +: DATA_W] = lfsr;
        ff_do[SRC_CNT_LSB +: CNT_W]   = sent_cnt;
    end

endmodule

//--- src/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import emu_pkg::*, target_pkg::*; (
    input  logic              host_clk,
    input  logic              rst_n,
    input  logic              step,
    input  logic              tgt_rst,
    input  logic              push,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    input  logic              ff_se,
    input  logic [SCAN_W-1:0] ff_di,
    input  logic              ram_scan_reset,
    input  logic              ram_scan,
    input  logic              ram_dir,
    input  logic [SCAN_W-1:0] ram_sdi,
    output logic              full,
    output logic              empty,
    output logic [DATA_W-1:0] head,
    output logic [SCAN_W-1:0] ff_do,
    output logic [SCAN_W-1:0] ram_sdo
);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;     // One extra bit to tell full from empty.
    logic [PTR_W-1:0]  ram_ptr;
    logic              wr_en;
    logic              rd_en;
    logic              ram_wr;
    logic              ram_rd;

    assign full  = (count == FIFO_DEPTH[PTR_W:0]);
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    assign wr_en = step & ~tgt_rst & push & ~full;
    assign rd_en = step & ~tgt_rst & pop & ~empty;

    // Host access to the memory only while the target is frozen.
    assign ram_wr = ~step & ram_scan & ram_dir;
    assign ram_rd = ~step & ram_scan & ~ram_dir;

    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (step) begin
            if (tgt_rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (wr_en)
                    wr_ptr <= wr_ptr + 1'b1;
                if (rd_en)
                    rd_ptr <= rd_ptr + 1'b1;
                case ({wr_en, rd_en})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end else if (ff_se) begin
            wr_ptr <= ff_di[FIFO_WR_LSB +: PTR_W];
            rd_ptr <= ff_di[FIFO_RD_LSB +: PTR_W];
            count  <= ff_di[FIFO_CNT_LSB +: PTR_W+1];
        end
    end

    // Memory is not touched by tgt_rst.
    always_ff @(posedge host_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end else if (ram_wr) begin
            mem[ram_ptr] <= ram_sdi[DATA_W-1:0];
        end
    end

    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            ram_ptr <= '0;
        end else if (!step) begin
            if (ram_scan_reset)
                ram_ptr <= '0;
            else if (ram_scan)
                ram_ptr <= ram_ptr + 1'b1;  // Wraps at FIFO_DEPTH.
        end
    end

    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            ram_sdo <= '0;
        end else if (ram_rd) begin
            ram_sdo <= SCAN_W'(mem[ram_ptr]);
        end
    end

    always_comb begin
        ff_do = '0;
        ff_do[FIFO_WR_LSB +: PTR_W]    = wr_ptr;
        ff_do[FIFO_RD_LSB +: PTR_W]    = rd_ptr;
        ff_do[FIFO_CNT_LSB +: PTR_W+1] = count;
    end

endmodule

//--- src/checksum_sink.sv
`timescale 1ns/1ps

module checksum_sink import emu_pkg::*, target_pkg::*; (
    input  logic              host_clk,
    input  logic              rst_n,
    input  logic              step,
    input  logic              tgt_rst,
    input  logic              empty,
    input  logic [DATA_W-1:0] head,
    input  logic              ff_se,
    input  logic [SCAN_W-1:0] ff_di,
    output logic              pop,
    output logic [SCAN_W-1:0] ff_do
);

    logic              tick;
    logic [CNT_W-1:0]  rcv_cnt;
    logic [DATA_W-1:0] sum;

    // Pops on every other step at most, so the FIFO backs up.
    assign pop = step & ~tgt_rst & ~empty & tick;

    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            tick    <= 1'b0;
            rcv_cnt <= '0;
            sum     <= '0;
        end else if (step) begin
            if (tgt_rst) begin
                tick    <= 1'b0;
                rcv_cnt <= '0;
                sum     <= '0;
            end else begin
                tick <= ~tick;
                if (pop) begin
                    rcv_cnt <= rcv_cnt + 1'b1;
                    sum     <= fold_sum(sum, head);
                end
            end
        end else if (ff_se) begin
            tick    <= ff_di[SNK_TICK];
            rcv_cnt <= ff_di[SNK_CNT_LSB +: CNT_W];
            sum     <= ff_di[SNK_SUM +: DATA_W];
        end
    end

    always_comb begin
        ff_do = '0;
        ff_do[SNK_SUM +: DATA_W]    = sum;
        ff_do[SNK_CNT_LSB +: CNT_W] = rcv_cnt;
        ff_do[SNK_TICK]             = tick;
    end

endmodule

//--- src/emu_top.sv
`timescale 1ns/1ps

module emu_top import emu_pkg::*, target_pkg::*; (
    input  logic              host_clk,
    input  logic              rst_n,
    input  logic              target_rst,
    input  logic              run_mode,
    input  logic              scan_mode,
    input  logic              pause,
    input  logic              ff_scan,
    input  logic              ff_dir,
    input  logic [SCAN_W-1:0] ff_sdi,
    input  logic              ram_scan_reset,
    input  logic              ram_scan,
    input  logic              ram_dir,
    input  logic [SCAN_W-1:0] ram_sdi,
    output logic [SCAN_W-1:0] ff_sdo,
    output logic [SCAN_W-1:0] ram_sdo,
    output logic              idle
);

    logic              step;
    logic              tgt_rst;
    logic              push;
    logic [DATA_W-1:0] push_data;
    logic              pop;
    logic              full;
    logic              empty;
    logic [DATA_W-1:0] head;

    // Word 0 is the chain input, each target module adds one word after it.
    logic [SCAN_W-1:0] chain [CHAIN_WORDS+1];

    // Loopback feeds ff_sdo back in when the host shifts without loading.
    assign chain[0] = ff_dir ? ff_sdi : ff_sdo;
    assign ff_sdo   = chain[CHAIN_WORDS];

    emu_ctrl u_ctrl (
        .host_clk   (host_clk),
        .rst_n      (rst_n),
        .run_mode   (run_mode),
        .scan_mode  (scan_mode),
        .pause      (pause),
        .ff_scan    (ff_scan),
        .ram_scan   (ram_scan),
        .target_rst (target_rst),
        .step       (step),
        .tgt_rst    (tgt_rst),
        .idle       (idle)
    );

    sample_source u_source (
        .host_clk  (host_clk),
        .rst_n     (rst_n),
        .step      (step),
        .tgt_rst   (tgt_rst),
        .full      (full),
        .ff_se     (ff_scan),
        .ff_di     (chain[0]),
        .push      (push),
        .push_data (push_data),
        .ff_do     (chain[1])
    );

    sample_fifo u_fifo (
        .host_clk       (host_clk),
        .rst_n          (rst_n),
        .step           (step),
        .tgt_rst        (tgt_rst),
        .push           (push),
        .push_data      (push_data),
        .pop            (pop),
        .ff_se          (ff_scan),
        .ff_di          (chain[1]),
        .ram_scan_reset (ram_scan_reset),
        .ram_scan       (ram_scan),
        .ram_dir        (ram_dir),
        .ram_sdi        (ram_sdi),
        .full           (full),
        .empty          (empty),
        .head           (head),
        .ff_do          (chain[2]),
        .ram_sdo        (ram_sdo)
    );

    checksum_sink u_sink (
        .host_clk (host_clk),
        .rst_n    (rst_n),
        .step     (step),
        .tgt_rst  (tgt_rst),
        .empty    (empty),
        .head     (head),
        .ff_se    (ff_scan),
        .ff_di    (chain[2]),
        .pop      (pop),
        .ff_do    (chain[3])  // Last word shows on ff_sdo.
    );

endmodule

//--- bench/emu_checker.sv
`timescale 1ns/1ps

module emu_checker import emu_pkg::*, target_pkg::*; (
    input  logic              host_clk,
    input  logic              rst_n,
    input  logic              target_rst,
    input  logic              run_mode,
    input  logic              scan_mode,
    input  logic              pause,
    input  logic              ff_scan,
    input  logic              ff_dir,
    input  logic [SCAN_W-1:0] ff_sdi,
    input  logic              ram_scan_reset,
    input  logic              ram_scan,
    input  logic              ram_dir,
    input  logic [SCAN_W-1:0] ram_sdi,
    input  logic [SCAN_W-1:0] ff_sdo,
    input  logic [SCAN_W-1:0] ram_sdo,
    input  logic              idle
);

    string test_name = "reset";
    int    err_count = 0;
    int    check_count = 0;

    // Model of the target and of the host side registers.
    logic [DATA_W-1:0] m_lfsr;
    logic [CNT_W-1:0]  m_sent;
    logic [DATA_W-1:0] m_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  m_wr;
    logic [PTR_W-1:0]  m_rd;
    logic [PTR_W:0]    m_cnt;
    logic [PTR_W-1:0]  m_ram_ptr;
    logic              m_tick;
    logic [CNT_W-1:0]  m_rcv;
    logic [DATA_W-1:0] m_sum;
    logic              m_step;     // Expected step from last cycle's controls.
    logic              m_pend;     // Target reset waiting for its step.
    logic              rd_due;
    logic [SCAN_W-1:0] rd_expect;
    logic              step_now;
    logic              push_now;
    logic              pop_now;
    logic [SCAN_W-1:0] src_w;
    logic [SCAN_W-1:0] fifo_w;
    logic [SCAN_W-1:0] sink_w;
    logic [SCAN_W-1:0] shift_in;

    // Galois form shifting right with the taps folded in on a set bit 0.
    function automatic logic [DATA_W-1:0] lfsr_advance(input logic [DATA_W-1:0] v);
        return {1'b0, v[DATA_W-1:1]} ^ ({DATA_W{v[0]}} & LFSR_TAPS);
    endfunction

    function automatic logic [DATA_W-1:0] sum_fold(input logic [DATA_W-1:0] s,
                                                   input logic [DATA_W-1:0] x);
        return ((s << 1) | (s >> (DATA_W - 1))) ^ x;
    endfunction

    task automatic set_test(input string name);
        test_name = name;
    endtask

    task automatic compare_value(input string what, input logic [SCAN_W-1:0] expected,
                                 input logic [SCAN_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    always @(posedge host_clk) begin
        if (!rst_n) begin
            m_lfsr    <= LFSR_SEED;
            m_sent    <= '0;
            m_wr      <= '0;
            m_rd      <= '0;
            m_cnt     <= '0;
            m_ram_ptr <= '0;
            m_tick    <= 1'b0;
            m_rcv     <= '0;
            m_sum     <= '0;
            m_step    <= 1'b0;
            m_pend    <= 1'b0;
            rd_due    <= 1'b0;
        end else begin
            step_now = ~idle;  // Model steps together with the DUT.
            src_w  = '0;
            src_w[SRC_CNT_LSB +: CNT_W]   = m_sent;
            src_w[SRC_LFSR_LSB +: DATA_W] = m_lfsr;
            fifo_w = '0;
            fifo_w[FIFO_WR_LSB +: PTR_W]    = m_wr;
            fifo_w[FIFO_RD_LSB +: PTR_W]    = m_rd;
            fifo_w[FIFO_CNT_LSB +: PTR_W+1] = m_cnt;
            sink_w = '0;
            sink_w[SNK_SUM +: DATA_W]    = m_sum;
            sink_w[SNK_CNT_LSB +: CNT_W] = m_rcv;
            sink_w[SNK_TICK]             = m_tick;

            compare_value("idle", {{(SCAN_W-1){1'b0}}, !m_step}, {{(SCAN_W-1){1'b0}}, idle});
            if (rd_due)
                compare_value("ram_sdo", rd_expect, ram_sdo);
            m_step <= run_mode & ~scan_mode & ~pause & ~ff_scan & ~ram_scan;
            m_pend <= target_rst | (m_pend & ~step_now);
            rd_due <= 1'b0;

            if (step_now && m_pend) begin
                m_lfsr <= LFSR_SEED;  // Memory keeps its contents.
                m_sent <= '0;
                m_wr   <= '0;
                m_rd   <= '0;
                m_cnt  <= '0;
                m_tick <= 1'b0;
                m_rcv  <= '0;
                m_sum  <= '0;
            end else if (step_now) begin
                push_now = (m_cnt != FIFO_DEPTH[PTR_W:0]);
                pop_now  = (m_cnt != '0) && m_tick;
                if (push_now) begin
                    m_mem[m_wr] <= m_lfsr;
                    m_wr        <= m_wr + 1'b1;
                    m_lfsr      <= lfsr_advance(m_lfsr);
                    m_sent      <= m_sent + 1'b1;
                end
                if (pop_now) begin
                    m_rd  <= m_rd + 1'b1;
                    m_rcv <= m_rcv + 1'b1;
                    m_sum <= sum_fold(m_sum, m_mem[m_rd]);
                end
                m_cnt  <= m_cnt + {{PTR_W{1'b0}}, push_now} - {{PTR_W{1'b0}}, pop_now};
                m_tick <= ~m_tick;
            end else begin
                if (ff_scan) begin
                    compare_value("ff_sdo", sink_w, ff_sdo);
                    shift_in = ff_dir ? ff_sdi : sink_w;
                    m_lfsr <= shift_in[SRC_LFSR_LSB +: DATA_W];
                    m_sent <= shift_in[SRC_CNT_LSB +: CNT_W];
                    m_wr   <= src_w[FIFO_WR_LSB +: PTR_W];
                    m_rd   <= src_w[FIFO_RD_LSB +: PTR_W];
                    m_cnt  <= src_w[FIFO_CNT_LSB +: PTR_W+1];
                    m_tick <= fifo_w[SNK_TICK];
                    m_rcv  <= fifo_w[SNK_CNT_LSB +: CNT_W];
                    m_sum  <= fifo_w[SNK_SUM +: DATA_W];
                end
                if (ram_scan && ram_dir)
                    m_mem[m_ram_ptr] <= ram_sdi[DATA_W-1:0];
                if (ram_scan && !ram_dir) begin
                    rd_due    <= 1'b1;  // Read data shows one cycle later.
                    rd_expect <= {{(SCAN_W-DATA_W){1'b0}}, m_mem[m_ram_ptr]};
                end
                if (ram_scan_reset)
                    m_ram_ptr <= '0;
                else if (ram_scan)
                    m_ram_ptr <= m_ram_ptr + 1'b1;
            end
        end
    end

endmodule

//--- bench/tb_emu_top.sv
`timescale 1ns/1ps

module tb_emu_top import emu_pkg::*, target_pkg::*; ();

    localparam int IDLE_TIMEOUT = 20;

    logic              host_clk;
    logic              rst_n;
    logic              target_rst;
    logic              run_mode;
    logic              scan_mode;
    logic              pause;
    logic              ff_scan;
    logic              ff_dir;
    logic [SCAN_W-1:0] ff_sdi;
    logic              ram_scan_reset;
    logic              ram_scan;
    logic              ram_dir;
    logic [SCAN_W-1:0] ram_sdi;
    logic [SCAN_W-1:0] ff_sdo;
    logic [SCAN_W-1:0] ram_sdo;
    logic              idle;
    logic [31:0]       lcg_state;
    int                tb_errors;
    int                total;

    emu_top u_dut (.*);

    emu_checker u_chk (.*);

    always #5 host_clk = ~host_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [SCAN_W-1:0] random_source_word();
        logic [SCAN_W-1:0] w;
        logic [31:0]       r;
        w = '0;
        r = lcg_next();
        w[SRC_CNT_LSB +: CNT_W]   = r[CNT_W-1:0];
        w[SRC_LFSR_LSB +: DATA_W] = lcg_next() | 32'h1;  // A zero LFSR never moves.
        return w;
    endfunction

    // Read pointer is random, the write pointer follows from the fill count.
    function automatic logic [SCAN_W-1:0] random_fifo_word(input int fill);
        logic [SCAN_W-1:0] w;
        logic [31:0]       r;
        logic [PTR_W:0]    cnt;
        w   = '0;
        r   = lcg_next();
        cnt = fill[PTR_W:0];
        w[FIFO_RD_LSB +: PTR_W]    = r[PTR_W-1:0];
        w[FIFO_WR_LSB +: PTR_W]    = r[PTR_W-1:0] + cnt[PTR_W-1:0];
        w[FIFO_CNT_LSB +: PTR_W+1] = cnt;
        return w;
    endfunction

    function automatic logic [SCAN_W-1:0] random_sink_word();
        logic [SCAN_W-1:0] w;
        logic [31:0]       r;
        w = '0;
        r = lcg_next();
        w[SNK_SUM +: DATA_W]    = lcg_next();
        w[SNK_CNT_LSB +: CNT_W] = r[CNT_W-1:0];
        w[SNK_TICK]             = r[31];
        return w;
    endfunction

    // idle is sampled on the falling edge, away from the register updates.
    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge host_clk);
        while (!idle && waited < IDLE_TIMEOUT) begin
            @(negedge host_clk);
            waited++;
        end
        if (!idle) begin
            tb_errors++;
            $display("Timeout in %s: idle stayed low for %0d cycles", u_chk.test_name, waited);
        end
        @(posedge host_clk);
    endtask

    task automatic run_steps(input int n);
        run_mode <= 1'b1;
        repeat (n) @(posedge host_clk);
        run_mode <= 1'b0;
        wait_idle();
    endtask

    // First word lands in the sink, the last one in the source.
    task automatic shift_words(input logic dir, input logic [SCAN_W-1:0] w0,
                               input logic [SCAN_W-1:0] w1, input logic [SCAN_W-1:0] w2);
        logic [SCAN_W-1:0] words [CHAIN_WORDS];
        words = '{w0, w1, w2};
        for (int i = 0; i < CHAIN_WORDS; i++) begin
            ff_scan <= 1'b1;
            ff_dir  <= dir;
            ff_sdi  <= words[i];
            @(posedge host_clk);
        end
        ff_scan <= 1'b0;
        ff_dir  <= 1'b0;
        ff_sdi  <= '0;
        @(posedge host_clk);
    endtask

    task automatic capture();
        shift_words(1'b0, '0, '0, '0);
    endtask

    task automatic load_state(input int fill);
        shift_words(1'b1, random_sink_word(), random_fifo_word(fill), random_source_word());
    endtask

    task automatic write_memory();
        ram_scan_reset <= 1'b1;
        @(posedge host_clk);
        ram_scan_reset <= 1'b0;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            ram_scan <= 1'b1;
            ram_dir  <= 1'b1;
            ram_sdi  <= {lcg_next(), lcg_next()};  // High half is dropped by the FIFO.
            @(posedge host_clk);
        end
        ram_scan <= 1'b0;
        ram_dir  <= 1'b0;
        @(posedge host_clk);
    endtask

    task automatic read_memory();
        ram_scan_reset <= 1'b1;
        @(posedge host_clk);
        ram_scan_reset <= 1'b0;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            ram_scan <= 1'b1;
            @(posedge host_clk);
        end
        ram_scan <= 1'b0;
        repeat (2) @(posedge host_clk);
    endtask

    initial begin
        host_clk       = 1'b0;
        rst_n          = 1'b0;
        target_rst     = 1'b0;
        run_mode       = 1'b0;
        scan_mode      = 1'b0;
        pause          = 1'b0;
        ff_scan        = 1'b0;
        ff_dir         = 1'b0;
        ff_sdi         = '0;
        ram_scan_reset = 1'b0;
        ram_scan       = 1'b0;
        ram_dir        = 1'b0;
        ram_sdi        = '0;
        lcg_state      = 32'h886d;
        tb_errors      = 0;
        repeat (2) @(posedge host_clk);
        rst_n <= 1'b1;
        @(posedge host_clk);

        u_chk.set_test("mem_fill");
        write_memory();
        u_chk.set_test("mem_read");
        read_memory();
        u_chk.set_test("run_capture");
        run_steps(4 + int'(lcg_next() % 60));
        load_state(int'(lcg_next() % (FIFO_DEPTH + 1)));
        u_chk.set_test("loopback");
        capture();
        capture();
        u_chk.set_test("state_load");
        load_state(int'(lcg_next() % (FIFO_DEPTH + 1)));
        run_steps(4 + int'(lcg_next() % 40));
        capture();
        u_chk.set_test("mem_load");
        load_state(FIFO_DEPTH);  // A full FIFO brings every written sample to the sink.
        write_memory();
        run_steps(2 * FIFO_DEPTH + 8);
        capture();
        read_memory();

        u_chk.set_test("freeze");
        run_mode <= 1'b1;
        pause    <= 1'b1;
        repeat (8) @(posedge host_clk);
        capture();
        pause     <= 1'b0;
        scan_mode <= 1'b1;
        repeat (8) @(posedge host_clk);
        capture();
        run_mode  <= 1'b0;
        scan_mode <= 1'b0;
        @(posedge host_clk);

        u_chk.set_test("target_rst");
        target_rst <= 1'b1;
        @(posedge host_clk);
        target_rst <= 1'b0;
        run_steps(1);
        capture();

        repeat (2) @(posedge host_clk);
        total = u_chk.err_count + tb_errors;
        $display("Checks: %0d, errors: %0d", u_chk.check_count, total);
        if (total == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- sources.f
src/emu_pkg.sv
src/target_pkg.sv
src/emu_ctrl.sv
src/sample_source.sv
src/sample_fifo.sv
src/checksum_sink.sv
src/emu_top.sv
bench/emu_checker.sv
bench/tb_emu_top.sv
